// ==== rtl/axi_wmux_pkg.sv ====
/*
 * Shared constants and types of the AXI4 write multiplexer
 * Port count, ID, address and data widths, W FIFO depth
 * AW lock state encoding
 */

`default_nettype none

package axi_wmux_pkg;

  //----------------------------------------
  // Sizes
  //----------------------------------------
  localparam int unsigned NUM_PORTS   = 4;                       // Slave ports
  localparam int unsigned PORT_IDX_W  = $clog2(NUM_PORTS);       // Bits to index a port
  localparam int unsigned SLV_ID_W    = 4;                       // ID width, slave side
  localparam int unsigned MST_ID_W    = SLV_ID_W + PORT_IDX_W;   // ID width, master side
  localparam int unsigned ADDR_W      = 32;
  localparam int unsigned DATA_W      = 32;

  // Writes with AW accepted but W not yet complete
  localparam int unsigned MAX_W_TRANS  = 4;
  localparam int unsigned W_FIFO_PTR_W = $clog2(MAX_W_TRANS);
  localparam int unsigned W_FIFO_CNT_W = $clog2(MAX_W_TRANS + 1); // Holds 0..MAX_W_TRANS

  //----------------------------------------
  // Types
  //----------------------------------------
  typedef logic [PORT_IDX_W-1:0] port_idx_t;
  typedef logic [SLV_ID_W-1:0]   slv_id_t;
  typedef logic [MST_ID_W-1:0]   mst_id_t;   // Port index in the upper bits
  typedef logic [ADDR_W-1:0]     addr_t;
  typedef logic [DATA_W-1:0]     data_t;

  // AW handshake lock, set once a presented AW has stalled
  typedef enum logic [0:0] {
    AW_FREE   = 1'b0,
    AW_LOCKED = 1'b1
  } aw_lock_e;

endpackage

`default_nettype wire

// ==== rtl/axi_wmux_rr_arb.sv ====
/*
 * Round-robin arbiter with lock-in for the AW requests
 * Valid/ready on both sides, payload muxed to the output
 */

`timescale 1ns/1ps
`default_nettype none

module axi_wmux_rr_arb (
  input  wire                                              clk_i,
  input  wire                                              arst_n_i,
  // Requests from all ports
  input  wire  [axi_wmux_pkg::NUM_PORTS-1:0]               req_i,
  input  axi_wmux_pkg::mst_id_t [axi_wmux_pkg::NUM_PORTS-1:0] id_i,
  input  axi_wmux_pkg::addr_t   [axi_wmux_pkg::NUM_PORTS-1:0] addr_i,
  output logic [axi_wmux_pkg::NUM_PORTS-1:0]               gnt_o,
  // Arbitrated request
  output logic                                             req_o,
  output axi_wmux_pkg::mst_id_t                            id_o,
  output axi_wmux_pkg::addr_t                              addr_o,
  output axi_wmux_pkg::port_idx_t                          idx_o,
  input  wire                                              gnt_i
);

  import axi_wmux_pkg::*;

  port_idx_t rr_q;       // Highest priority port
  port_idx_t rr_next;    // Port after the winner
  port_idx_t sel_q;      // Choice held while locked
  logic      lock_q;     // Request shown but not yet taken
  port_idx_t rr_idx;     // Free-running search result
  port_idx_t cand;
  logic      found;

  // First requester at or after the pointer
  always_comb begin
    found  = 1'b0;
    rr_idx = rr_q;
    cand   = rr_q;
    for (int off = 0; off < NUM_PORTS; off++) begin
      cand = port_idx_t'((int'(rr_q) + off) % NUM_PORTS);
      if (!found && req_i[cand]) begin
        rr_idx = cand;
        found  = 1'b1;
      end
    end
  end

  assign idx_o  = lock_q ? sel_q : rr_idx;           // Lock-in keeps the old winner
  assign req_o  = lock_q ? req_i[sel_q] : found;
  assign id_o   = id_i[idx_o];
  assign addr_o = addr_i[idx_o];

  // Ready back only to the winner
  always_comb begin
    gnt_o = '0;
    if (req_o && gnt_i) begin
      gnt_o[idx_o] = 1'b1;
    end
  end

  assign rr_next = (idx_o == port_idx_t'(NUM_PORTS - 1)) ? '0 : idx_o + 1'b1;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rr_q   <= '0;
      lock_q <= 1'b0;
      sel_q  <= '0;
    end else begin
      if (req_o && gnt_i) rr_q <= rr_next;      // Move past the winner
      lock_q <= req_o & ~gnt_i;                 // Stalled, hold next cycle
      if (!lock_q) sel_q <= idx_o;
    end
  end

  // Single winner at any time
  a_gnt_onehot : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    $onehot0(gnt_o));

  // A stalled request keeps its port until taken
  a_lock_hold : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    req_o && !gnt_i |=> req_o && (idx_o == $past(idx_o)));

endmodule

`default_nettype wire

// ==== rtl/axi_wmux_aw_ctrl.sv ====
/*
 * AW handshake control between arbiter and master port
 * Stalls on a full W FIFO, pushes once per AW
 */

`timescale 1ns/1ps
`default_nettype none

module axi_wmux_aw_ctrl (
  input  wire  clk_i,
  input  wire  arst_n_i,
  // Arbiter side
  input  wire  arb_valid_i,
  output logic arb_ready_o,
  // W FIFO
  input  wire  fifo_full_i,
  output logic fifo_push_o,
  // Master AW handshake
  output logic mst_aw_valid_o,
  input  wire  mst_aw_ready_i
);

  import axi_wmux_pkg::*;

  aw_lock_e state_q, state_d;

  always_comb begin
    state_d        = state_q;
    arb_ready_o    = 1'b0;
    fifo_push_o    = 1'b0;
    mst_aw_valid_o = 1'b0;
    case (state_q)
      AW_LOCKED: begin
        // Already pushed, just finish the handshake
        mst_aw_valid_o = 1'b1;
        if (mst_aw_ready_i) begin
          arb_ready_o = 1'b1;
          state_d     = AW_FREE;
        end
      end
      default: begin
        if (arb_valid_i && !fifo_full_i) begin
          mst_aw_valid_o = 1'b1;
          fifo_push_o    = 1'b1;       // Port index into W order
          if (mst_aw_ready_i) begin
            arb_ready_o = 1'b1;
          end else begin
            state_d = AW_LOCKED;       // No second push on retry
          end
        end
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) state_q <= AW_FREE;
    else           state_q <= state_d;
  end

  // Valid stays up once shown, until the master takes it
  a_aw_valid_stable : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    mst_aw_valid_o && !mst_aw_ready_i |=> mst_aw_valid_o);

endmodule

`default_nettype wire

// ==== rtl/axi_wmux_w_fifo.sv ====
/*
 * W order FIFO, one port index per accepted AW
 * Circular buffer, registered output, no fall-through
 */

`timescale 1ns/1ps
`default_nettype none

module axi_wmux_w_fifo (
  input  wire                     clk_i,
  input  wire                     arst_n_i,
  input  wire                     push_i,
  input  wire                     pop_i,
  input  axi_wmux_pkg::port_idx_t data_i,
  output axi_wmux_pkg::port_idx_t data_o,
  output logic                    full_o,
  output logic                    empty_o
);

  import axi_wmux_pkg::*;

  port_idx_t                 mem [MAX_W_TRANS];
  logic [W_FIFO_PTR_W-1:0]   wr_ptr_q;
  logic [W_FIFO_PTR_W-1:0]   rd_ptr_q;
  logic [W_FIFO_CNT_W-1:0]   cnt_q;
  logic                      do_push;
  logic                      do_pop;

  assign full_o  = (cnt_q == W_FIFO_CNT_W'(MAX_W_TRANS));
  assign empty_o = (cnt_q == '0);
  assign data_o  = mem[rd_ptr_q];          // Head of queue

  assign do_push = push_i & ~full_o;
  assign do_pop  = pop_i & ~empty_o;

  // Storage
  always_ff @(posedge clk_i) begin
    if (do_push) mem[wr_ptr_q] <= data_i;
  end

  // Pointers and fill level
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == W_FIFO_PTR_W'(MAX_W_TRANS - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == W_FIFO_PTR_W'(MAX_W_TRANS - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: cnt_q <= cnt_q;          // Both or neither
      endcase
    end
  end

  // AW control must hold off on full
  a_no_push_full : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !(push_i && full_o));

  // W routing must only pop a real entry
  a_no_pop_empty : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !(pop_i && empty_o));

endmodule

`default_nettype wire

// ==== rtl/axi_wmux_w_route.sv ====
/*
 * W beat multiplexer, steered by the W FIFO head
 * Pops the FIFO on the last beat of a burst
 */

`timescale 1ns/1ps
`default_nettype none

module axi_wmux_w_route (
  // W FIFO head
  input  axi_wmux_pkg::port_idx_t                           sel_i,
  input  wire                                               empty_i,
  output logic                                              pop_o,
  // Slave side W
  input  axi_wmux_pkg::data_t [axi_wmux_pkg::NUM_PORTS-1:0] slv_w_data_i,
  input  wire  [axi_wmux_pkg::NUM_PORTS-1:0]                slv_w_last_i,
  input  wire  [axi_wmux_pkg::NUM_PORTS-1:0]                slv_w_valid_i,
  output logic [axi_wmux_pkg::NUM_PORTS-1:0]                slv_w_ready_o,
  // Master side W
  output axi_wmux_pkg::data_t                               mst_w_data_o,
  output logic                                              mst_w_last_o,
  output logic                                              mst_w_valid_o,
  input  wire                                               mst_w_ready_i
);

  // Payload follows the head, valid gated below
  assign mst_w_data_o = slv_w_data_i[sel_i];
  assign mst_w_last_o = slv_w_last_i[sel_i];

  always_comb begin
    mst_w_valid_o = 1'b0;
    slv_w_ready_o = '0;
    pop_o         = 1'b0;
    if (!empty_i) begin
      mst_w_valid_o        = slv_w_valid_i[sel_i];
      slv_w_ready_o[sel_i] = mst_w_ready_i;          // Other ports stay stalled
      // Burst done, next AW order entry
      pop_o = slv_w_valid_i[sel_i] & mst_w_ready_i & slv_w_last_i[sel_i];
    end
  end

endmodule

`default_nettype wire

// ==== rtl/axi_wmux_b_route.sv ====
/*
 * B response demultiplexer
 * Routes by the ID prefix and strips it
 */

`timescale 1ns/1ps
`default_nettype none

module axi_wmux_b_route (
  // Master side B
  input  axi_wmux_pkg::mst_id_t              mst_b_id_i,
  input  wire  [1:0]                         mst_b_resp_i,
  input  wire                                mst_b_valid_i,
  output logic                               mst_b_ready_o,
  // Slave side B, payload shared by all ports
  output axi_wmux_pkg::slv_id_t              slv_b_id_o,
  output logic [1:0]                         slv_b_resp_o,
  output logic [axi_wmux_pkg::NUM_PORTS-1:0] slv_b_valid_o,
  input  wire  [axi_wmux_pkg::NUM_PORTS-1:0] slv_b_ready_i
);

  import axi_wmux_pkg::*;

  port_idx_t b_idx;

  assign b_idx         = mst_b_id_i[MST_ID_W-1 -: PORT_IDX_W];   // Prefix bits
  assign slv_b_id_o    = mst_b_id_i[SLV_ID_W-1:0];
  assign slv_b_resp_o  = mst_b_resp_i;
  assign slv_b_valid_o = mst_b_valid_i ? (NUM_PORTS'(1) << b_idx) : '0;
  assign mst_b_ready_o = slv_b_ready_i[b_idx];                   // Addressed port only

endmodule

`default_nettype wire

// ==== rtl/axi_wmux.sv ====
/*
 * AXI4 write multiplexer top level
 * ID prepend, AW arbitration and control, W order FIFO
 * W routing and B routing
 */

`timescale 1ns/1ps
`default_nettype none

module axi_wmux (
  input  wire                                                clk_i,
  input  wire                                                arst_n_i,
  // Slave ports
  input  axi_wmux_pkg::slv_id_t [axi_wmux_pkg::NUM_PORTS-1:0] slv_aw_id_i,
  input  axi_wmux_pkg::addr_t   [axi_wmux_pkg::NUM_PORTS-1:0] slv_aw_addr_i,
  input  wire  [axi_wmux_pkg::NUM_PORTS-1:0]                 slv_aw_valid_i,
  output logic [axi_wmux_pkg::NUM_PORTS-1:0]                 slv_aw_ready_o,
  input  axi_wmux_pkg::data_t   [axi_wmux_pkg::NUM_PORTS-1:0] slv_w_data_i,
  input  wire  [axi_wmux_pkg::NUM_PORTS-1:0]                 slv_w_last_i,
  input  wire  [axi_wmux_pkg::NUM_PORTS-1:0]                 slv_w_valid_i,
  output logic [axi_wmux_pkg::NUM_PORTS-1:0]                 slv_w_ready_o,
  output axi_wmux_pkg::slv_id_t [axi_wmux_pkg::NUM_PORTS-1:0] slv_b_id_o,
  output logic [axi_wmux_pkg::NUM_PORTS-1:0][1:0]            slv_b_resp_o,
  output logic [axi_wmux_pkg::NUM_PORTS-1:0]                 slv_b_valid_o,
  input  wire  [axi_wmux_pkg::NUM_PORTS-1:0]                 slv_b_ready_i,
  // Master port
  output axi_wmux_pkg::mst_id_t                              mst_aw_id_o,
  output axi_wmux_pkg::addr_t                                mst_aw_addr_o,
  output logic                                               mst_aw_valid_o,
  input  wire                                                mst_aw_ready_i,
  output axi_wmux_pkg::data_t                                mst_w_data_o,
  output logic                                               mst_w_last_o,
  output logic                                               mst_w_valid_o,
  input  wire                                                mst_w_ready_i,
  input  axi_wmux_pkg::mst_id_t                              mst_b_id_i,
  input  wire  [1:0]                                         mst_b_resp_i,
  input  wire                                                mst_b_valid_i,
  output logic                                               mst_b_ready_o
);

  import axi_wmux_pkg::*;

  mst_id_t [NUM_PORTS-1:0] aw_id_pre;     // Slave IDs with port index on top

  logic      arb_valid, arb_ready;        // Arbiter output handshake
  port_idx_t arb_idx;                     // Winning port

  logic      fifo_push, fifo_pop;
  logic      fifo_full, fifo_empty;
  port_idx_t fifo_head;                   // Port owning the current W burst

  slv_id_t   b_id;
  logic [1:0] b_resp;

  //----------------------------------------
  // ID prepend
  //----------------------------------------
  for (genvar i = 0; i < NUM_PORTS; i++) begin : gen_id_prepend
    assign aw_id_pre[i] = {port_idx_t'(i), slv_aw_id_i[i]};
  end

  //----------------------------------------
  // AW channel
  //----------------------------------------
  axi_wmux_rr_arb i_aw_arb (
    .clk_i    ( clk_i          ),
    .arst_n_i ( arst_n_i       ),
    .req_i    ( slv_aw_valid_i ),
    .id_i     ( aw_id_pre      ),
    .addr_i   ( slv_aw_addr_i  ),
    .gnt_o    ( slv_aw_ready_o ),
    .req_o    ( arb_valid      ),
    .id_o     ( mst_aw_id_o    ),  // Payload straight to the master
    .addr_o   ( mst_aw_addr_o  ),
    .idx_o    ( arb_idx        ),
    .gnt_i    ( arb_ready      )
  );

  axi_wmux_aw_ctrl i_aw_ctrl (
    .clk_i          ( clk_i          ),
    .arst_n_i       ( arst_n_i       ),
    .arb_valid_i    ( arb_valid      ),
    .arb_ready_o    ( arb_ready      ),
    .fifo_full_i    ( fifo_full      ),
    .fifo_push_o    ( fifo_push      ),
    .mst_aw_valid_o ( mst_aw_valid_o ),
    .mst_aw_ready_i ( mst_aw_ready_i )
  );

  axi_wmux_w_fifo i_w_fifo (
    .clk_i    ( clk_i      ),
    .arst_n_i ( arst_n_i   ),
    .push_i   ( fifo_push  ),
    .pop_i    ( fifo_pop   ),
    .data_i   ( arb_idx    ),
    .data_o   ( fifo_head  ),
    .full_o   ( fifo_full  ),
    .empty_o  ( fifo_empty )
  );

  //----------------------------------------
  // W channel
  //----------------------------------------
  axi_wmux_w_route i_w_route (
    .sel_i         ( fifo_head     ),
    .empty_i       ( fifo_empty    ),
    .pop_o         ( fifo_pop      ),
    .slv_w_data_i  ( slv_w_data_i  ),
    .slv_w_last_i  ( slv_w_last_i  ),
    .slv_w_valid_i ( slv_w_valid_i ),
    .slv_w_ready_o ( slv_w_ready_o ),
    .mst_w_data_o  ( mst_w_data_o  ),
    .mst_w_last_o  ( mst_w_last_o  ),
    .mst_w_valid_o ( mst_w_valid_o ),
    .mst_w_ready_i ( mst_w_ready_i )
  );

  //----------------------------------------
  // B channel
  //----------------------------------------
  axi_wmux_b_route i_b_route (
    .mst_b_id_i    ( mst_b_id_i    ),
    .mst_b_resp_i  ( mst_b_resp_i  ),
    .mst_b_valid_i ( mst_b_valid_i ),
    .mst_b_ready_o ( mst_b_ready_o ),
    .slv_b_id_o    ( b_id          ),
    .slv_b_resp_o  ( b_resp        ),
    .slv_b_valid_o ( slv_b_valid_o ),
    .slv_b_ready_i ( slv_b_ready_i )
  );

  // Same B payload at every port, valid picks the owner
  for (genvar i = 0; i < NUM_PORTS; i++) begin : gen_b_fanout
    assign slv_b_id_o[i]   = b_id;
    assign slv_b_resp_o[i] = b_resp;
  end

endmodule

`default_nettype wire

// ==== verification/tb_axi_wmux.sv ====
/*
 * Testbench for the AXI4 write multiplexer
 * Per-port AW and W drivers, master-side slave model with B replies
 * Reference ID function and a negedge checker process
 */

`timescale 1ns/1ps
`default_nettype none

module tb_axi_wmux;

  import axi_wmux_pkg::*;

  localparam int WR_PER_PORT = 8;     // Same count on every port keeps all four requesting
  localparam int TMO         = 400;   // Cycles per wait
  localparam int RUN_LIMIT   = 20000;

  logic clk;
  logic arst_n;
  slv_id_t [NUM_PORTS-1:0]        slv_aw_id;
  addr_t   [NUM_PORTS-1:0]        slv_aw_addr;
  logic    [NUM_PORTS-1:0]        slv_aw_valid, slv_aw_ready;
  data_t   [NUM_PORTS-1:0]        slv_w_data;
  logic    [NUM_PORTS-1:0]        slv_w_last, slv_w_valid, slv_w_ready;
  slv_id_t [NUM_PORTS-1:0]        slv_b_id;
  logic    [NUM_PORTS-1:0][1:0]   slv_b_resp;
  logic    [NUM_PORTS-1:0]        slv_b_valid, slv_b_ready;
  mst_id_t mst_aw_id;
  addr_t   mst_aw_addr;
  logic    mst_aw_valid, mst_aw_ready;
  data_t   mst_w_data;
  logic    mst_w_last, mst_w_valid, mst_w_ready;
  mst_id_t mst_b_id;
  logic [1:0] mst_b_resp;
  logic    mst_b_valid, mst_b_ready;

  logic [15:0] lfsr = 16'd50;
  slv_id_t   job_id_q  [NUM_PORTS][$];  // AW accepted, W still to send
  int        job_len_q [NUM_PORTS][$];
  int        cur_len   [NUM_PORTS];     // Burst length of the AW on offer
  mst_id_t   pend_q[$];                 // Model side, AW order
  logic [7:0] b_q[$];                   // {resp, id} waiting for B
  mst_id_t   exp_w_q[$];                // Checker side, AW order
  int        exp_len_q[$];
  port_idx_t rr_hist[$];
  int  err_reset, err_aw, err_hold, err_rr, err_w, err_b;
  int  b_done;
  logic timed_out, done;

  axi_wmux DUT (
    .clk_i          ( clk          ), .arst_n_i       ( arst_n       ),
    .slv_aw_id_i    ( slv_aw_id    ), .slv_aw_addr_i  ( slv_aw_addr  ),
    .slv_aw_valid_i ( slv_aw_valid ), .slv_aw_ready_o ( slv_aw_ready ),
    .slv_w_data_i   ( slv_w_data   ), .slv_w_last_i   ( slv_w_last   ),
    .slv_w_valid_i  ( slv_w_valid  ), .slv_w_ready_o  ( slv_w_ready  ),
    .slv_b_id_o     ( slv_b_id     ), .slv_b_resp_o   ( slv_b_resp   ),
    .slv_b_valid_o  ( slv_b_valid  ), .slv_b_ready_i  ( slv_b_ready  ),
    .mst_aw_id_o    ( mst_aw_id    ), .mst_aw_addr_o  ( mst_aw_addr  ),
    .mst_aw_valid_o ( mst_aw_valid ), .mst_aw_ready_i ( mst_aw_ready ),
    .mst_w_data_o   ( mst_w_data   ), .mst_w_last_o   ( mst_w_last   ),
    .mst_w_valid_o  ( mst_w_valid  ), .mst_w_ready_i  ( mst_w_ready  ),
    .mst_b_id_i     ( mst_b_id     ), .mst_b_resp_i   ( mst_b_resp   ),
    .mst_b_valid_i  ( mst_b_valid  ), .mst_b_ready_o  ( mst_b_ready  )
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  //----------------------------------------
  // Helpers
  //----------------------------------------
  // Galois LFSR, one step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
      r    = {r[30:0], lfsr[0]};
    end
    return r;
  endfunction

  // Port index on top of the slave ID
  function automatic mst_id_t expected_mst_id(input int port, input slv_id_t id);
    return {port_idx_t'(port), id};
  endfunction

  function automatic logic last_four_distinct();
    logic [NUM_PORTS-1:0] seen;
    seen = '0;
    for (int i = rr_hist.size() - 4; i < rr_hist.size(); i++) begin
      seen[rr_hist[i]] = 1'b1;
    end
    return seen == '1;
  endfunction

  task automatic report_stall(input string what, input int p);
    $display("Timeout at %0t: %s never completed on port %0d", $time, what, p);
    timed_out = 1'b1;
  endtask

  //----------------------------------------
  // Per-port drivers
  //----------------------------------------
  task automatic drive_aw(input int p);
    int t;
    for (int n = 0; n < WR_PER_PORT; n++) begin
      slv_aw_id[p]    = slv_id_t'(rand_bits(SLV_ID_W));
      slv_aw_addr[p]  = addr_t'(rand_bits(28) << 4);
      cur_len[p]      = int'(rand_bits(2)) + 1;        // Burst of 1 to 4
      slv_aw_valid[p] = 1'b1;                        // Stays up across writes
      t = 0;
      @(negedge clk);
      while (!slv_aw_ready[p]) begin
        t = t + 1;
        if (t > TMO || timed_out) begin
          report_stall("AW", p);
          return;
        end
        @(negedge clk);
      end
      job_id_q[p].push_back(slv_aw_id[p]);
      job_len_q[p].push_back(cur_len[p]);
      @(posedge clk);
      #2;
    end
    slv_aw_valid[p] = 1'b0;
  endtask

  task automatic drive_w(input int p);
    int      t;
    int      len;
    slv_id_t id;
    for (int n = 0; n < WR_PER_PORT; n++) begin
      t = 0;
      while (job_len_q[p].size() == 0) begin
        t = t + 1;
        if (t > TMO || timed_out) begin
          report_stall("W job", p);
          return;
        end
        @(posedge clk);
        #2;
      end
      id  = job_id_q[p].pop_front();
      len = job_len_q[p].pop_front();
      for (int b = 0; b < len; b++) begin
        slv_w_data[p]  = {8'(p), 4'h0, id, 8'(len), 8'(b)};  // Port, ID, length, beat
        slv_w_last[p]  = (b == len - 1);
        slv_w_valid[p] = 1'b1;
        t = 0;
        @(negedge clk);
        while (!slv_w_ready[p]) begin
          t = t + 1;
          if (t > TMO || timed_out) begin
            report_stall("W beat", p);
            return;
          end
          @(negedge clk);
        end
        @(posedge clk);
        #2;
        slv_w_valid[p] = 1'b0;
      end
    end
  endtask

  //----------------------------------------
  // Master-side slave model
  //----------------------------------------
  initial begin
    mst_aw_ready = 1'b0;
    mst_w_ready  = 1'b0;
    mst_b_valid  = 1'b0;
    mst_b_id     = '0;
    mst_b_resp   = 2'b00;
    slv_b_ready  = '0;
    for (int cyc = 0; cyc < RUN_LIMIT && !done; cyc++) begin
      @(negedge clk);
      if (arst_n && mst_aw_valid && mst_aw_ready) pend_q.push_back(mst_aw_id);
      if (arst_n && mst_w_valid && mst_w_ready && mst_w_last && pend_q.size() != 0) begin
        b_q.push_back({2'(rand_bits(2)), pend_q.pop_front()});  // B in AW order
      end
      if (mst_b_valid && mst_b_ready) void'(b_q.pop_front());
      @(posedge clk);
      #2;
      mst_aw_ready = (rand_bits(2) != 0);   // Ready three cycles out of four
      mst_w_ready  = (rand_bits(2) != 0);
      slv_b_ready  = NUM_PORTS'(rand_bits(NUM_PORTS));
      mst_b_valid  = (b_q.size() != 0);
      if (b_q.size() != 0) {mst_b_resp, mst_b_id} = b_q[0];
    end
  end

  //----------------------------------------
  // Checker, samples where all outputs are settled
  //----------------------------------------
  mst_id_t held_id;
  addr_t   held_addr;
  logic    aw_stalled = 1'b0;
  int      w_beat = 0;
  int      w_len  = 0;

  always @(negedge clk) begin : check_blk
    int        win;
    port_idx_t pre;
    mst_id_t   head;
    logic      exp_v;
    if (arst_n) begin
      if (aw_stalled) begin
        assert (mst_aw_valid && mst_aw_id == held_id && mst_aw_addr == held_addr) else begin
          err_hold++;
          $display("ERR %0t: AW changed before accept, id %h addr %h", $time, mst_aw_id,
                   mst_aw_addr);
        end
      end
      aw_stalled = mst_aw_valid && !mst_aw_ready;
      held_id    = mst_aw_id;
      held_addr  = mst_aw_addr;
      if (mst_aw_valid && mst_aw_ready) begin
        win = 0;
        for (int q = 0; q < NUM_PORTS; q++) if (slv_aw_ready[q]) win = q;
        assert ($onehot(slv_aw_ready) && mst_aw_id == expected_mst_id(win, slv_aw_id[win])
                && mst_aw_addr == slv_aw_addr[win]) else begin
          err_aw++;
          $display("ERR %0t: AW id %h addr %h, port %0d expects %h %h", $time, mst_aw_id,
                   mst_aw_addr, win, expected_mst_id(win, slv_aw_id[win]), slv_aw_addr[win]);
        end
        exp_w_q.push_back(expected_mst_id(win, slv_aw_id[win]));
        exp_len_q.push_back(cur_len[win]);
        rr_hist.push_back(port_idx_t'(win));
        if (rr_hist.size() >= 4) begin
          assert (last_four_distinct()) else begin
            err_rr++;
            $display("ERR %0t: last four AW grants not from four ports", $time);
          end
        end
      end
      if (mst_w_valid && mst_w_ready) begin
        head  = (exp_w_q.size() != 0) ? exp_w_q[0] : '0;
        w_len = (exp_len_q.size() != 0) ? exp_len_q[0] : 0;   // Length chosen with the AW
        assert (exp_w_q.size() != 0 &&
                mst_w_data == {8'(head[MST_ID_W-1 -: PORT_IDX_W]), 4'h0,
                               head[SLV_ID_W-1:0], 8'(w_len), 8'(w_beat)} &&
                mst_w_last == (w_beat == w_len - 1)) else begin
          err_w++;
          $display("ERR %0t: W beat %0d data %h last %b for AW id %h", $time, w_beat,
                   mst_w_data, mst_w_last, head);
        end
        w_beat = w_beat + 1;
        if (mst_w_last) begin
          w_beat = 0;
          if (exp_w_q.size() != 0) void'(exp_w_q.pop_front());
          if (exp_len_q.size() != 0) void'(exp_len_q.pop_front());
        end
      end
      pre = mst_b_id[MST_ID_W-1 -: PORT_IDX_W];
      for (int q = 0; q < NUM_PORTS; q++) begin
        exp_v = mst_b_valid && (port_idx_t'(q) == pre);
        assert (slv_b_valid[q] == exp_v && (!exp_v || (slv_b_id[q] == mst_b_id[SLV_ID_W-1:0]
                && slv_b_resp[q] == mst_b_resp))) else begin
          err_b++;
          $display("ERR %0t: B at port %0d valid %b id %h resp %h, master id %h", $time, q,
                   slv_b_valid[q], slv_b_id[q], slv_b_resp[q], mst_b_id);
        end
        if (slv_b_valid[q] && slv_b_ready[q]) b_done++;
      end
      // Master B ready follows the addressed port
      if (mst_b_valid) begin
        assert (mst_b_ready == slv_b_ready[pre]) else begin
          err_b++;
          $display("ERR %0t: master B ready %b, port %0d ready %b", $time, mst_b_ready,
                   pre, slv_b_ready[pre]);
        end
      end
    end
  end

  //----------------------------------------
  // Main sequence
  //----------------------------------------
  initial begin
    int cyc;
    {err_reset, err_aw, err_hold, err_rr, err_w, err_b, b_done} = '0;
    timed_out    = 1'b0;
    done         = 1'b0;
    arst_n       = 1'b0;
    slv_aw_id    = '0;
    slv_aw_addr  = '0;
    slv_aw_valid = '0;
    slv_w_data   = '0;
    slv_w_last   = '0;
    slv_w_valid  = '1;             // Beats offered early, empty FIFO must hold them
    repeat (4) @(posedge clk);
    @(negedge clk);
    assert (!mst_aw_valid && !mst_w_valid && slv_b_valid == '0 && slv_aw_ready == '0
            && slv_w_ready == '0) else begin
      err_reset++;
      $display("ERR %0t: outputs active in reset", $time);
    end
    @(posedge clk);
    #2;
    arst_n      = 1'b1;
    slv_w_valid = '0;
    fork
      drive_aw(0);
      drive_aw(1);
      drive_aw(2);
      drive_aw(3);
      drive_w(0);
      drive_w(1);
      drive_w(2);
      drive_w(3);
    join_none
    cyc = 0;
    while (b_done < NUM_PORTS * WR_PER_PORT && !timed_out) begin
      cyc = cyc + 1;
      if (cyc > RUN_LIMIT) begin
        $display("Timeout: only %0d of %0d B responses arrived", b_done,
                 NUM_PORTS * WR_PER_PORT);
        timed_out = 1'b1;
      end
      @(negedge clk);
    end
    done = 1'b1;
    $display("Errors: reset %0d, aw %0d, aw hold %0d, rr %0d, w %0d, b %0d", err_reset,
             err_aw, err_hold, err_rr, err_w, err_b);
    if (timed_out || (err_reset + err_aw + err_hold + err_rr + err_w + err_b) != 0) begin
      $display("Something failed");
    end else begin
      $display("Everything OK");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== axi_wmux.f ====
rtl/axi_wmux_pkg.sv
rtl/axi_wmux_rr_arb.sv
rtl/axi_wmux_aw_ctrl.sv
rtl/axi_wmux_w_fifo.sv
rtl/axi_wmux_w_route.sv
rtl/axi_wmux_b_route.sv
rtl/axi_wmux.sv
verification/tb_axi_wmux.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the AXI write mux testbench with Verilator, run it, look for the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_axi_wmux -f axi_wmux.f -o sim_axi_wmux &&
./obj_dir/sim_axi_wmux | tee /dev/stderr | grep -q "Everything OK" &&
echo "Simulation passed" ||
{ echo "Simulation or build failed"; exit 1; }
